// ==== design/jesd204_rx_64b_pkg.sv ====
/*
  Shared types, link state encoding, register map and lock thresholds
  for the JESD204C 64b/66b receive link control. Compile it ahead of
  the RTL and import it where a type or constant is needed.
*/
`default_nettype none

package jesd204_rx_64b_pkg;

  // 2-bit sync header with the pilot bit on top
  typedef logic [1:0] sync_hdr_t;

  // APB byte address and data word
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // consecutive good cycles seen by the link FSM
  typedef logic [5:0] good_cnt_t;

  typedef enum logic [1:0] {
    st_reset      = 2'b00,
    st_wait_bs    = 2'b01,
    st_block_sync = 2'b10,
    st_data       = 2'b11
  } link_state_t;

  // register map
  localparam apb_addr_t reg_lanes_disable = 8'h00;
  localparam apb_addr_t reg_status        = 8'h04;
  localparam apb_addr_t reg_block_sync    = 8'h08;
  localparam apb_addr_t reg_emb_lock      = 8'h0C;
  localparam apb_addr_t reg_err_count     = 8'h10;

  // block alignment thresholds in headers
  localparam int unsigned bs_lock_count  = 64;
  localparam int unsigned bs_loss_count  = 4;

  // extended multiblock framing
  localparam int unsigned emb_blocks     = 32;
  localparam int unsigned emb_lock_count = 4;
  localparam int unsigned emb_loss_count = 2;

endpackage

`default_nettype wire

// ==== design/rx_lane_block_sync.sv ====
/*
  Per-lane sync header alignment detector. Hunts for a run of legal
  headers and holds block_sync until a run of illegal ones breaks it.
  One instance per lane, fed by the lane's header strobe.
*/
`default_nettype none
`timescale 1ns/1ps

module rx_lane_block_sync
  import jesd204_rx_64b_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      hdr_valid,
  input  wire sync_hdr_t sync_hdr,
  output logic           block_sync
);

  typedef enum logic {
    bs_hunt,
    bs_locked
  } bs_state_t;

  localparam int unsigned vld_w = $clog2(bs_lock_count);
  localparam int unsigned inv_w = $clog2(bs_loss_count);

  bs_state_t        state;
  logic [vld_w-1:0] vld_cnt;
  logic [inv_w-1:0] inv_cnt;
  logic             hdr_ok;

  // 01 and 10 are the only legal headers
  assign hdr_ok = ^sync_hdr;

  // strobe-less cycles leave both run counters alone
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= bs_hunt;
      vld_cnt <= '0;
      inv_cnt <= '0;
    end else if (hdr_valid) begin
      case (state)
        bs_hunt: begin
          inv_cnt <= '0;
          if (!hdr_ok) begin
            vld_cnt <= '0;
          end else if (vld_cnt == vld_w'(bs_lock_count - 1)) begin
            vld_cnt <= '0;
            state   <= bs_locked;
          end else begin
            vld_cnt <= vld_cnt + 1'b1;
          end
        end
        bs_locked: begin
          vld_cnt <= '0;
          if (hdr_ok) begin
            inv_cnt <= '0;
          end else if (inv_cnt == inv_w'(bs_loss_count - 1)) begin
            inv_cnt <= '0;
            state   <= bs_hunt;
          end else begin
            inv_cnt <= inv_cnt + 1'b1;
          end
        end
        default: begin
          state <= bs_hunt;
        end
      endcase
    end
  end

  assign block_sync = (state == bs_locked);

  // lock can only be gained on a sampled header
  a_lock_needs_hdr : assert property (
    @(posedge clk) disable iff (reset)
    $rose(block_sync) |-> $past(hdr_valid)
  );

endmodule

`default_nettype wire

// ==== design/rx_lane_emb_lock.sv ====
/*
  Per-lane extended multiblock lock. Watches the pilot bit stream for
  the 0,0,0,0,1 end-of-multiblock marker and checks its spacing.
  Sits beside rx_lane_block_sync and is held off while that is unlocked.
*/
`default_nettype none
`timescale 1ns/1ps

module rx_lane_emb_lock
  import jesd204_rx_64b_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      hdr_valid,
  input  wire sync_hdr_t sync_hdr,
  input  wire logic      block_sync,
  output logic           emb_lock
);

  typedef enum logic [1:0] {
    emb_hunt,
    emb_check,
    emb_locked
  } emb_state_t;

  localparam int unsigned pos_w  = $clog2(emb_blocks);
  localparam int unsigned hit_w  = $clog2(emb_lock_count);
  localparam int unsigned miss_w = $clog2(emb_loss_count);
  localparam logic [4:0]  emb_marker = 5'b00001;

  emb_state_t        state;
  logic [3:0]        pilot_hist;
  logic [4:0]        pilot_win;
  logic [pos_w-1:0]  pos;
  logic [hit_w-1:0]  hit_cnt;
  logic [miss_w-1:0] miss_cnt;
  logic              marker;
  logic              at_expect;

  // oldest pilot bit in the msb, current header in the lsb
  assign pilot_win = {pilot_hist, sync_hdr[1]};
  assign marker    = hdr_valid && (pilot_win == emb_marker);
  assign at_expect = (pos == pos_w'(emb_blocks - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      // all ones so the first header cannot complete a marker
      pilot_hist <= '1;
      pos        <= '0;
    end else if (hdr_valid) begin
      pilot_hist <= pilot_win[3:0];
      if ((state == emb_hunt && marker) || at_expect) begin
        pos <= '0;
      end else begin
        pos <= pos + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !block_sync) begin
      state    <= emb_hunt;
      hit_cnt  <= '0;
      miss_cnt <= '0;
    end else if (hdr_valid) begin
      case (state)
        emb_hunt: begin
          if (marker) begin
            state   <= emb_check;
            hit_cnt <= '0;
          end
        end
        // stray markers between positions are payload and ignored
        emb_check: begin
          if (at_expect) begin
            if (!marker) begin
              state <= emb_hunt;
            end else if (hit_cnt == hit_w'(emb_lock_count - 1)) begin
              state    <= emb_locked;
              miss_cnt <= '0;
            end else begin
              hit_cnt <= hit_cnt + 1'b1;
            end
          end
        end
        emb_locked: begin
          if (at_expect) begin
            if (marker) begin
              miss_cnt <= '0;
            end else if (miss_cnt == miss_w'(emb_loss_count - 1)) begin
              state <= emb_hunt;
            end else begin
              miss_cnt <= miss_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= emb_hunt;
        end
      endcase
    end
  end

  assign emb_lock = (state == emb_locked);

  a_emb_needs_bs : assert property (
    @(posedge clk) disable iff (reset)
    !block_sync |=> !emb_lock
  );

endmodule

`default_nettype wire

// ==== design/rx_ctrl_64b.sv ====
/*
  Link state machine for the 64b/66b receiver. Combines per-lane block
  and multiblock lock, with disabled lanes counted as locked, and walks
  the link from reset to data. Drops out of data raise an event pulse.
*/
`default_nettype none
`timescale 1ns/1ps

module rx_ctrl_64b
  import jesd204_rx_64b_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic [num_lanes-1:0] cfg_lanes_disable,
  input  wire logic [num_lanes-1:0] block_sync,
  input  wire logic [num_lanes-1:0] emb_lock,
  input  wire logic                 buffer_release_n,
  output link_state_t               link_state,
  output logic                      unexpected_event
);

  link_state_t          next_state;
  good_cnt_t            good_cnt;
  logic                 good_clr;
  logic                 event_nx;
  logic [num_lanes-1:0] bs_masked;
  logic [num_lanes-1:0] emb_masked;
  logic                 all_bs;
  logic                 all_emb;

  // two register stages that mask each lane and then reduce
  always_ff @(posedge clk) begin
    if (reset) begin
      bs_masked  <= '0;
      emb_masked <= '0;
      all_bs     <= 1'b0;
      all_emb    <= 1'b0;
    end else begin
      bs_masked  <= block_sync | cfg_lanes_disable;
      emb_masked <= emb_lock | cfg_lanes_disable;
      all_bs     <= &bs_masked;
      all_emb    <= &emb_masked;
    end
  end

  always_comb begin
    next_state = link_state;
    good_clr   = 1'b1;
    event_nx   = 1'b0;
    case (link_state)
      st_reset: begin
        next_state = st_wait_bs;
      end
      st_wait_bs: begin
        if (all_bs) begin
          good_clr = 1'b0;
          if (&good_cnt) begin
            next_state = st_block_sync;
          end
        end
      end
      st_block_sync: begin
        if (!all_bs) begin
          next_state = st_wait_bs;
        end else if (all_emb && !buffer_release_n) begin
          good_clr = 1'b0;
          if (&good_cnt) begin
            next_state = st_data;
          end
        end
      end
      st_data: begin
        if (!all_bs) begin
          next_state = st_wait_bs;
          event_nx   = 1'b1;
        end else if (!all_emb || buffer_release_n) begin
          next_state = st_block_sync;
          event_nx   = 1'b1;
        end
      end
      default: begin
        next_state = st_reset;
      end
    endcase
  end

  // forward steps need 64 good cycles in a row
  always_ff @(posedge clk) begin
    if (reset || good_clr) begin
      good_cnt <= '0;
    end else begin
      good_cnt <= good_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      link_state       <= st_reset;
      unexpected_event <= 1'b0;
    end else begin
      link_state       <= next_state;
      unexpected_event <= event_nx;
    end
  end

  a_event_from_data : assert property (
    @(posedge clk) disable iff (reset)
    unexpected_event |-> $past(link_state) == st_data
  );

endmodule

`default_nettype wire

// ==== design/rx_apb_regs.sv ====
/*
  APB register slave for the receive link control. Holds the lane
  disable mask, reads back link state and lane lock status, and counts
  unexpected link events. Read data and response are set up in the
  setup phase, so every access completes without wait states.
*/
`default_nettype none
`timescale 1ns/1ps

module rx_apb_regs
  import jesd204_rx_64b_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 psel,
  input  wire logic                 penable,
  input  wire logic                 pwrite,
  input  wire apb_addr_t            paddr,
  input  wire apb_data_t            pwdata,
  output apb_data_t                 prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic [num_lanes-1:0]      cfg_lanes_disable,
  input  wire link_state_t          link_state,
  input  wire logic [num_lanes-1:0] block_sync,
  input  wire logic [num_lanes-1:0] emb_lock,
  input  wire logic                 unexpected_event
);

  logic        setup_ph;
  logic        access_ph;
  logic        wr_en;
  logic        addr_ok;
  logic        err_clr;
  apb_data_t   rd_data;
  logic [15:0] err_count;

  assign setup_ph  = psel && !penable;
  assign access_ph = psel && penable;
  assign wr_en     = access_ph && pwrite;
  assign err_clr   = wr_en && (paddr == reg_err_count);

  // address decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    rd_data = '0;
    case (paddr)
      reg_lanes_disable: rd_data = apb_data_t'(cfg_lanes_disable);
      reg_status:        rd_data = apb_data_t'(link_state);
      reg_block_sync:    rd_data = apb_data_t'(block_sync);
      reg_emb_lock:      rd_data = apb_data_t'(emb_lock);
      reg_err_count:     rd_data = apb_data_t'(err_count);
      default:           addr_ok = 1'b0;
    endcase
  end

  // response for the access phase is registered at the end of setup
  always_ff @(posedge clk) begin
    if (reset) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= setup_ph;
      pslverr <= setup_ph && !addr_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_ph) begin
      prdata <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_lanes_disable <= '0;
    end else if (wr_en && paddr == reg_lanes_disable) begin
      cfg_lanes_disable <= pwdata[num_lanes-1:0];
    end
  end

  // saturating event counter; an event landing on a clear still counts
  always_ff @(posedge clk) begin
    if (reset) begin
      err_count <= '0;
    end else if (err_clr) begin
      err_count <= unexpected_event ? 16'd1 : 16'd0;
    end else if (unexpected_event && err_count != 16'hffff) begin
      err_count <= err_count + 1'b1;
    end
  end

  a_no_wait_states : assert property (
    @(posedge clk) disable iff (reset)
    access_ph |-> pready
  );

endmodule

`default_nettype wire

// ==== design/rx_link_top.sv ====
/*
  Top level of the 64b/66b receive link control. One block sync and one
  multiblock lock detector per lane feed the link FSM, which in turn
  reports to the APB register block.
*/
`default_nettype none
`timescale 1ns/1ps

module rx_link_top
  import jesd204_rx_64b_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic [num_lanes-1:0]   hdr_valid,
  input  wire logic [2*num_lanes-1:0] sync_hdr,
  input  wire logic                   buffer_release_n,
  input  wire logic                   psel,
  input  wire logic                   penable,
  input  wire logic                   pwrite,
  input  wire apb_addr_t              paddr,
  input  wire apb_data_t              pwdata,
  output apb_data_t                   prdata,
  output logic                        pready,
  output logic                        pslverr
);

  logic [num_lanes-1:0] block_sync;
  logic [num_lanes-1:0] emb_lock;
  logic [num_lanes-1:0] cfg_lanes_disable;
  link_state_t          link_state;
  logic                 unexpected_event;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    rx_lane_block_sync i_block_sync (
      .clk        (clk),
      .reset      (reset),
      .hdr_valid  (hdr_valid[i]),
      .sync_hdr   (sync_hdr[2*i +: 2]),
      .block_sync (block_sync[i])
    );

    rx_lane_emb_lock i_emb_lock (
      .clk        (clk),
      .reset      (reset),
      .hdr_valid  (hdr_valid[i]),
      .sync_hdr   (sync_hdr[2*i +: 2]),
      .block_sync (block_sync[i]),
      .emb_lock   (emb_lock[i])
    );
  end

  rx_ctrl_64b #(
    .num_lanes (num_lanes)
  ) i_ctrl (
    .clk               (clk),
    .reset             (reset),
    .cfg_lanes_disable (cfg_lanes_disable),
    .block_sync        (block_sync),
    .emb_lock          (emb_lock),
    .buffer_release_n  (buffer_release_n),
    .link_state        (link_state),
    .unexpected_event  (unexpected_event)
  );

  rx_apb_regs #(
    .num_lanes (num_lanes)
  ) i_regs (
    .clk               (clk),
    .reset             (reset),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .pready            (pready),
    .pslverr           (pslverr),
    .cfg_lanes_disable (cfg_lanes_disable),
    .link_state        (link_state),
    .block_sync        (block_sync),
    .emb_lock          (emb_lock),
    .unexpected_event  (unexpected_event)
  );

endmodule

`default_nettype wire

// ==== verification/rx_link_tb.sv ====
/*
  Directed testbench for the receive link control. A lane model sends
  sync headers with end-of-multiblock markers on every lane, and the
  tests use APB to configure lanes and to poll status. It runs bring-up,
  lane disable, block sync loss, buffer release and multiblock loss.
*/
`default_nettype none
`timescale 1ns/1ps

module rx_link_tb
  import jesd204_rx_64b_pkg::*;
();

  localparam int unsigned num_lanes   = 4;
  localparam int          hdrs_per_mb = 32;
  localparam int          max_polls   = 1000;
  localparam apb_data_t   all_lanes   = apb_data_t'((1 << num_lanes) - 1);

  logic                   clk;
  logic                   reset;
  logic [num_lanes-1:0]   hdr_valid;
  logic [2*num_lanes-1:0] sync_hdr;
  logic                   buffer_release_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  apb_addr_t              paddr;
  apb_data_t              pwdata;
  apb_data_t              prdata;
  logic                   pready;
  logic                   pslverr;

  // lane model controls
  logic        lanes_on;
  int          bad_left  [num_lanes];
  logic        no_marker [num_lanes];
  int          lane_pos  [num_lanes];
  int          checks;
  int          errors;

  rx_link_top #(
    .num_lanes (num_lanes)
  ) i_dut (
    .clk              (clk),
    .reset            (reset),
    .hdr_valid        (hdr_valid),
    .sync_hdr         (sync_hdr),
    .buffer_release_n (buffer_release_n),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr)
  );

  always #10 clk = ~clk;

  // one header per lane per cycle; marker pilots 0,0,0,0,1 close each multiblock
  task automatic drive_lanes();
    int          i;
    logic        p;
    int unsigned rnd;
    for (i = 0; i < num_lanes; i++) begin
      if (!lanes_on) begin
        hdr_valid[i]         = 1'b0;
        sync_hdr[2*i +: 2]   = 2'b00;
      end else begin
        rnd = $urandom;
        if (lane_pos[i] == hdrs_per_mb - 1) begin
          p = 1'b1;
        end else if (lane_pos[i] >= hdrs_per_mb - 5) begin
          p = 1'b0;
        end else begin
          p = rnd[0];
        end
        if (no_marker[i]) begin
          p = 1'b1;
        end
        hdr_valid[i] = 1'b1;
        if (bad_left[i] > 0) begin
          sync_hdr[2*i +: 2] = 2'b11;
          bad_left[i]        = bad_left[i] - 1;
        end else begin
          sync_hdr[2*i +: 2] = {p, ~p};
        end
        lane_pos[i] = (lane_pos[i] + 1) % hdrs_per_mb;
      end
    end
  endtask

  // the lane model process owns the random stream
  initial begin
    void'($urandom(32'hd97e));
    forever begin
      @(posedge clk);
      #1;
      drive_lanes();
    end
  end

  task automatic check_value(input string name, input apb_data_t exp, input apb_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s: expected 0x%h actual 0x%h", name, exp, act);
    end
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int n;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    n = 0;
    while (!pready && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!pready) begin
      errors++;
      $display("apb access to 0x%h got no pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input string name, input apb_addr_t addr, input apb_data_t data);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, addr, data, rd, err);
    if (err) begin
      errors++;
      $display("%s: write to 0x%h returned an unexpected pslverr", name, addr);
    end
  endtask

  task automatic apb_read_check(input string name, input apb_addr_t addr, input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    apb_access(1'b0, addr, '0, rd, err);
    if (err) begin
      errors++;
      $display("%s: read of 0x%h returned an unexpected pslverr", name, addr);
    end
    check_value(name, exp, rd);
  endtask

  task automatic wait_reg(input string name, input apb_addr_t addr, input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    int        n;
    n  = 0;
    rd = '1;
    while (rd !== exp && n < max_polls) begin
      apb_access(1'b0, addr, '0, rd, err);
      n++;
    end
    checks++;
    if (rd !== exp) begin
      errors++;
      $display("%s: timed out waiting for register 0x%h to read 0x%h, last read 0x%h",
               name, addr, exp, rd);
    end
  endtask

  task automatic wait_state(input string name, input link_state_t st);
    wait_reg(name, reg_status, apb_data_t'(st));
  endtask

  task automatic test_reset_defaults();
    apb_data_t rd;
    logic      err;
    apb_read_check("reset_defaults", reg_lanes_disable, '0);
    apb_read_check("reset_defaults", reg_err_count, '0);
    apb_read_check("reset_defaults", reg_status, apb_data_t'(st_wait_bs));
    apb_write("reset_defaults", reg_lanes_disable, 32'h0000_000a);
    apb_read_check("reset_defaults", reg_lanes_disable, 32'h0000_000a);
    apb_write("reset_defaults", reg_lanes_disable, '0);
    apb_read_check("reset_defaults", reg_lanes_disable, '0);
    // 0x14 lies past the register map
    apb_access(1'b0, 8'h14, '0, rd, err);
    check_value("reset_defaults_pslverr", 32'd1, apb_data_t'(err));
  endtask

  task automatic test_bring_up();
    buffer_release_n = 1'b0;
    lanes_on         = 1'b1;
    wait_state("bring_up", st_data);
    apb_read_check("bring_up", reg_block_sync, all_lanes);
    apb_read_check("bring_up", reg_emb_lock, all_lanes);
  endtask

  task automatic test_lane_disable();
    apb_write("lane_disable", reg_lanes_disable, 32'h0000_0008);
    bad_left[3] = 1 << 30;
    wait_reg("lane_disable", reg_block_sync, all_lanes & ~32'h8);
    apb_read_check("lane_disable", reg_status, apb_data_t'(st_data));
    apb_read_check("lane_disable", reg_err_count, '0);
    // lane 3 must lock again before it is unmasked
    bad_left[3] = 0;
    wait_reg("lane_disable", reg_emb_lock, all_lanes);
    apb_write("lane_disable", reg_lanes_disable, '0);
    apb_read_check("lane_disable", reg_status, apb_data_t'(st_data));
  endtask

  task automatic test_bs_loss();
    bad_left[0] = 4;
    wait_state("bs_loss", st_wait_bs);
    apb_read_check("bs_loss", reg_err_count, 32'd1);
    apb_write("bs_loss", reg_err_count, '0);
    apb_read_check("bs_loss", reg_err_count, '0);
  endtask

  task automatic test_buffer_release();
    wait_state("buffer_release", st_data);
    apb_read_check("buffer_release", reg_err_count, '0);
    buffer_release_n = 1'b1;
    wait_state("buffer_release", st_block_sync);
    apb_read_check("buffer_release", reg_err_count, 32'd1);
    buffer_release_n = 1'b0;
    wait_state("buffer_release", st_data);
  endtask

  task automatic test_emb_loss();
    no_marker[1] = 1'b1;
    wait_reg("emb_loss", reg_emb_lock, all_lanes & ~32'h2);
    apb_read_check("emb_loss", reg_block_sync, all_lanes);
    wait_state("emb_loss", st_block_sync);
    apb_read_check("emb_loss", reg_err_count, 32'd2);
  endtask

  initial begin
    clk              = 1'b0;
    reset            = 1'b1;
    hdr_valid        = '0;
    sync_hdr         = '0;
    buffer_release_n = 1'b1;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    lanes_on         = 1'b0;
    checks           = 0;
    errors           = 0;
    for (int i = 0; i < num_lanes; i++) begin
      bad_left[i]  = 0;
      no_marker[i] = 1'b0;
      lane_pos[i]  = 0;
    end

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;

    test_reset_defaults();
    test_bring_up();
    test_lane_disable();
    test_bs_loss();
    test_buffer_release();
    test_emb_loss();

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
design/jesd204_rx_64b_pkg.sv
design/rx_lane_block_sync.sv
design/rx_lane_emb_lock.sv
design/rx_ctrl_64b.sv
design/rx_apb_regs.sv
design/rx_link_top.sv
verification/rx_link_tb.sv
